/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bch_decoder_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* logic/bch_berlekamp.sv */
`timescale 1ns/100ps

module bch_berlekamp (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     syn_valid,
	input  bch_code_pkg::syn_vec_t   syn,
	input  bch_code_pkg::code_word_t syn_word,
	output logic                     syn_ready,
	output logic                     sig_valid,
	output bch_code_pkg::sigma_vec_t sigma,
	output bch_code_pkg::deg_t       sig_deg,
	output bch_code_pkg::code_word_t sig_word,
	input  logic                     sig_ready
);

	localparam int gm = bch_gf_pkg::gf_m;
	localparam int nt = bch_code_pkg::code_t;

	bch_code_pkg::bm_state_t state;
	logic [1:0] iter;                               // Iteration, step n = 2*iter + 3
	logic [1:0] term;                               // Sigma term in discrepancy
	logic shift_ph;                                 // Second cycle of update
	logic bsel;                                     // Beta from last sigma
	bch_code_pkg::deg_t l_reg;                      // Current sigma length L

	bch_gf_pkg::gf_elem_t sig_r [0:nt];             // Sigma coefficients
	bch_gf_pkg::gf_elem_t beta [0:nt];              // x^m * B(x)
	bch_gf_pkg::gf_elem_t sig_last [0:nt];          // Sigma before update
	bch_gf_pkg::gf_elem_t d_r;                      // Discrepancy accumulator
	bch_gf_pkg::gf_elem_t d_p;                      // Previous nonzero discrepancy
	bch_code_pkg::syn_vec_t syn_r;
	bch_code_pkg::code_word_t word_r;

	bch_gf_pkg::gf_elem_t s1;
	bch_gf_pkg::gf_elem_t s_sel;                    // S_(n - term)
	bch_gf_pkg::gf_elem_t d_eff;
	bch_gf_pkg::gf_elem_t d_rp;                     // d_r * d_p^-1
	logic [2:0] step_n;
	int s_idx;

	assign s1 = syn[gm-1:0];
	assign step_n = {iter, 1'b1} + 3'd2;
	assign syn_ready = (state == bch_code_pkg::bm_idle);
	assign sig_valid = (state == bch_code_pkg::bm_done);

	// Syndrome select, out of range reads zero
	always_comb begin
		s_idx = int'(step_n) - int'(term);
		s_sel = '0;
		if (s_idx >= 1 && s_idx <= 2 * nt) begin
			s_sel = syn_r[(s_idx-1)*gm +: gm];
		end
	end

	// Only steps 3 and 5 are needed, the last pass leaves sigma alone
	assign d_eff = (iter == 2'd2) ? '0 : d_r;
	assign d_rp = bch_gf_pkg::gf_mul(d_eff, bch_gf_pkg::gf_inv(d_p));

	// ************************************************
	// Control FSM
	// ************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= bch_code_pkg::bm_idle;
			iter <= '0;
			term <= '0;
			shift_ph <= 1'b0;
		end else begin
			case (state)
				bch_code_pkg::bm_idle: begin
					if (syn_valid) begin
						state <= bch_code_pkg::bm_disc;
						iter <= '0;
						term <= '0;
					end
				end
				bch_code_pkg::bm_disc: begin
					term <= term + 2'd1;
					if (term == 2'(nt)) begin
						state <= bch_code_pkg::bm_update;  // All four terms summed
						shift_ph <= 1'b0;
					end
				end
				bch_code_pkg::bm_update: begin
					shift_ph <= ~shift_ph;
					if (shift_ph) begin
						iter <= iter + 2'd1;
						state <= (iter == 2'(nt - 1)) ? bch_code_pkg::bm_done
							: bch_code_pkg::bm_disc;
					end
				end
				bch_code_pkg::bm_done: begin
					if (sig_ready) begin
						state <= bch_code_pkg::bm_idle;    // Handed to Chien
					end
				end
				default: state <= bch_code_pkg::bm_idle;
			endcase
		end
	end

	// ************************************************
	// Datapath
	// ************************************************
	always_ff @(posedge clk) begin
		case (state)
			bch_code_pkg::bm_idle: begin
				if (syn_valid) begin
					syn_r <= syn;
					word_r <= syn_word;
					sig_r[0] <= bch_gf_pkg::gf_elem_t'(1);  // 1 + S1 x
					sig_r[1] <= s1;
					sig_r[2] <= '0;
					sig_r[3] <= '0;
					beta[0] <= '0;
					beta[1] <= '0;
					beta[2] <= (s1 != '0) ? bch_gf_pkg::gf_elem_t'(1) : '0; // x^2
					beta[3] <= (s1 != '0) ? '0 : bch_gf_pkg::gf_elem_t'(1); // x^3
					d_p <= (s1 != '0) ? s1 : bch_gf_pkg::gf_elem_t'(1);
					l_reg <= (s1 != '0) ? 3'd1 : 3'd0;
				end
			end
			bch_code_pkg::bm_disc: begin
				d_r <= ((term == 2'd0) ? '0 : d_r)
					^ bch_gf_pkg::gf_mul(sig_r[term], s_sel);  // One term per cycle
			end
			bch_code_pkg::bm_update: begin
				if (!shift_ph) begin
					for (int i = 0; i <= nt; i++) begin
						sig_last[i] <= sig_r[i];
						sig_r[i] <= sig_r[i] ^ bch_gf_pkg::gf_mul(d_rp, beta[i]);
					end
					bsel <= 1'b0;
					if (d_eff != '0 && {l_reg, 1'b0} <= {1'b0, step_n - 3'd1}) begin
						bsel <= 1'b1;                   // Length change
						l_reg <= step_n - l_reg;
						d_p <= d_eff;
					end
				end else begin
					beta[0] <= '0;                      // Beta times x^2
					beta[1] <= '0;
					beta[2] <= bsel ? sig_last[0] : beta[0];
					beta[3] <= bsel ? sig_last[1] : beta[1];
				end
			end
			default: ;
		endcase
	end

	// Highest nonzero coefficient
	always_comb begin
		sig_deg = '0;
		for (int i = 1; i <= nt; i++) begin
			if (sig_r[i] != '0) begin
				sig_deg = 3'(i);
			end
		end
		if (l_reg > 3'(nt)) begin
			sig_deg = l_reg;                            // Terms above x^3 not kept
		end
	end

	always_comb begin
		for (int i = 0; i <= nt; i++) begin
			sigma[i*gm +: gm] = sig_r[i];
		end
	end

	assign sig_word = word_r;

endmodule

/* logic/bch_chien.sv */
`timescale 1ns/100ps

module bch_chien (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     sig_valid,
	input  bch_code_pkg::sigma_vec_t sigma,
	input  bch_code_pkg::deg_t       sig_deg,
	input  bch_code_pkg::code_word_t sig_word,
	output logic                     sig_ready,
	output logic                     out_valid,
	output logic                     out_bit,
	output logic                     out_last,
	output logic                     out_fail,
	output bch_code_pkg::deg_t       out_nerr,
	input  logic                     out_ready
);

	localparam int gm = bch_gf_pkg::gf_m;
	localparam int nt = bch_code_pkg::code_t;
	localparam int nn = bch_code_pkg::code_n;

	bch_code_pkg::chien_state_t state;
	logic [3:0] pos;                                // Search index, then output position
	logic [4:0] root_cnt;                           // Wide, a bad sigma may have many roots
	logic [4:0] root_total;                         // Roots including the current cycle
	bch_gf_pkg::gf_elem_t term [0:nt];              // sigma_j * alpha^(-i*j)
	bch_gf_pkg::gf_elem_t eval;                     // sigma(alpha^-i)
	bch_code_pkg::code_word_t mask;
	bch_code_pkg::code_word_t word_r;
	bch_code_pkg::deg_t deg_r;
	logic fail;

	always_comb begin
		eval = '0;
		for (int j = 0; j <= nt; j++) begin
			eval = eval ^ term[j];
		end
	end

	assign root_total = root_cnt + ((eval == '0) ? 5'd1 : 5'd0);
	assign fail = (root_total != {2'b00, deg_r});
	assign sig_ready = (state == bch_code_pkg::ch_idle);
	assign out_valid = (state == bch_code_pkg::ch_stream);
	assign out_bit = word_r[pos];
	assign out_last = out_valid && (pos == 4'd0);

	// ************************************************
	// FSM and counters
	// ************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= bch_code_pkg::ch_idle;
			pos <= '0;
			root_cnt <= '0;
			out_fail <= 1'b0;
			out_nerr <= '0;
		end else begin
			case (state)
				bch_code_pkg::ch_idle: begin
					if (sig_valid) begin
						state <= bch_code_pkg::ch_search;
						pos <= '0;
						root_cnt <= '0;
					end
				end
				bch_code_pkg::ch_search: begin
					if (eval == '0) begin
						root_cnt <= root_cnt + 5'd1;    // Root at alpha^-i
					end
					pos <= pos + 4'd1;
					if (pos == 4'(nn - 1)) begin
						state <= bch_code_pkg::ch_stream;
						pos <= 4'(nn - 1);              // Stream from position 14
						out_fail <= fail;               // Held for the whole word
						out_nerr <= root_total[2:0];
					end
				end
				bch_code_pkg::ch_stream: begin
					if (out_ready) begin
						pos <= pos - 4'd1;
						if (pos == 4'd0) begin
							state <= bch_code_pkg::ch_idle;
						end
					end
				end
				default: state <= bch_code_pkg::ch_idle;
			endcase
		end
	end

	// ************************************************
	// Search datapath
	// ************************************************
	always_ff @(posedge clk) begin
		case (state)
			bch_code_pkg::ch_idle: begin
				if (sig_valid) begin
					for (int j = 0; j <= nt; j++) begin
						term[j] <= sigma[j*gm +: gm];
					end
					word_r <= sig_word;
					deg_r <= sig_deg;
					mask <= '0;
				end
			end
			bch_code_pkg::ch_search: begin
				for (int j = 0; j <= nt; j++) begin
					term[j] <= bch_gf_pkg::gf_mul(term[j],
						bch_gf_pkg::gf_alpha_pow((nn - j) % nn));  // alpha^-j
				end
				if (eval == '0) begin
					mask[pos] <= 1'b1;                  // Error at position i
				end
				if (pos == 4'(nn - 1) && !fail) begin
					// Last search cycle folds in its own root
					word_r <= word_r ^ mask
						^ ((eval == '0) ? bch_code_pkg::code_word_t'(1) << pos : '0);
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/bch_code_pkg.sv */
package bch_code_pkg;

	// ************************************************
	// (15,5) triple error correcting BCH code
	// ************************************************

	localparam int code_n = 15;         // Word length
	localparam int code_t = 3;          // Correctable errors

	typedef logic [code_n-1:0] code_word_t;                       // Received or corrected word
	typedef logic [2*code_t*bch_gf_pkg::gf_m-1:0] syn_vec_t;      // S6..S1, S1 in low nibble
	typedef logic [(code_t+1)*bch_gf_pkg::gf_m-1:0] sigma_vec_t;  // sigma3..sigma0
	typedef logic [2:0] deg_t;                                    // Degree or error count

	// Solver FSM
	typedef enum logic [1:0] {
		bm_idle,
		bm_disc,        // Serial discrepancy, one sigma term per cycle
		bm_update,      // Inversion/update, then beta shift
		bm_done
	} bm_state_t;

	// Chien search and output FSM
	typedef enum logic [1:0] {
		ch_idle,
		ch_search,
		ch_stream
	} chien_state_t;

endpackage

/* logic/bch_decoder_top.sv */
`timescale 1ns/100ps

module bch_decoder_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic               in_bit,
	output logic               in_ready,
	output logic               out_valid,
	output logic               out_bit,
	output logic               out_last,
	output logic               out_fail,
	output bch_code_pkg::deg_t out_nerr,
	input  logic               out_ready
);

	// Syndrome to solver
	logic syn_valid;
	logic syn_ready;
	bch_code_pkg::syn_vec_t syn;
	bch_code_pkg::code_word_t syn_word;

	// Solver to Chien
	logic sig_valid;
	logic sig_ready;
	bch_code_pkg::sigma_vec_t sigma;
	bch_code_pkg::deg_t sig_deg;
	bch_code_pkg::code_word_t sig_word;

	bch_syndrome u_syndrome (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_bit    (in_bit),
		.in_ready  (in_ready),
		.syn_valid (syn_valid),
		.syn       (syn),
		.syn_word  (syn_word),
		.syn_ready (syn_ready)
	);

	bch_berlekamp u_berlekamp (
		.clk       (clk),
		.rst_n     (rst_n),
		.syn_valid (syn_valid),
		.syn       (syn),
		.syn_word  (syn_word),
		.syn_ready (syn_ready),
		.sig_valid (sig_valid),
		.sigma     (sigma),
		.sig_deg   (sig_deg),
		.sig_word  (sig_word),
		.sig_ready (sig_ready)
	);

	bch_chien u_chien (
		.clk       (clk),
		.rst_n     (rst_n),
		.sig_valid (sig_valid),
		.sigma     (sigma),
		.sig_deg   (sig_deg),
		.sig_word  (sig_word),
		.sig_ready (sig_ready),
		.out_valid (out_valid),
		.out_bit   (out_bit),
		.out_last  (out_last),
		.out_fail  (out_fail),
		.out_nerr  (out_nerr),
		.out_ready (out_ready)
	);

endmodule

/* logic/bch_gf_pkg.sv */
package bch_gf_pkg;

	// ************************************************
	// GF(2^4) field definitions
	// ************************************************

	localparam int gf_m = 4;                        // Field degree
	localparam logic [gf_m:0] gf_poly = 5'b10011;  // x^4 + x + 1

	typedef logic [gf_m-1:0] gf_elem_t;             // One field element

	// Polynomial-basis product, MSB-first shift and add
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		p = '0;
		for (int i = gf_m - 1; i >= 0; i--) begin
			p = {p[gf_m-2:0], 1'b0} ^ (p[gf_m-1] ? gf_poly[gf_m-1:0] : '0); // Times x, reduce
			if (b[i]) begin
				p = p ^ a;                          // Add partial product
			end
		end
		return p;
	endfunction

	// Inverse as a^(2^m - 2), zero maps to zero
	function automatic gf_elem_t gf_inv(input gf_elem_t a);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < (1 << gf_m) - 2; i++) begin
			r = gf_mul(r, a);                       // One more power of a
		end
		return r;
	endfunction

	// Alpha to a small exponent, 0 .. 2^m - 2
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < (1 << gf_m) - 1; i++) begin
			if (i < e) begin
				r = gf_mul(r, gf_elem_t'(2));       // Alpha is x
			end
		end
		return r;
	endfunction

endpackage

/* logic/bch_syndrome.sv */
`timescale 1ns/100ps

module bch_syndrome (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic                    in_bit,
	output logic                    in_ready,
	output logic                    syn_valid,
	output bch_code_pkg::syn_vec_t  syn,
	output bch_code_pkg::code_word_t syn_word,
	input  logic                    syn_ready
);

	localparam int n_syn = 2 * bch_code_pkg::code_t;  // S1..S6

	logic [3:0] bit_cnt;                            // Word position of next beat
	bch_gf_pkg::gf_elem_t s_reg [1:n_syn];          // Syndrome accumulators
	bch_gf_pkg::gf_elem_t s_next [1:n_syn];
	bch_code_pkg::code_word_t word_buf;             // Received bits
	logic beat;

	assign beat = in_valid & in_ready;
	assign in_ready = ~syn_valid;                   // Hold off while a word waits

	// ************************************************
	// Horner step, S_j = S_j * alpha^j + r
	// ************************************************
	always_comb begin
		for (int j = 1; j <= n_syn; j++) begin
			s_next[j] = bch_gf_pkg::gf_mul((bit_cnt == 4'd0) ? '0 : s_reg[j],
				bch_gf_pkg::gf_alpha_pow(j)) ^ bch_gf_pkg::gf_elem_t'(in_bit);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			syn_valid <= 1'b0;
		end else begin
			if (beat) begin
				if (bit_cnt == 4'(bch_code_pkg::code_n - 1)) begin
					bit_cnt <= '0;                  // Word complete
					syn_valid <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (syn_valid && syn_ready) begin
				syn_valid <= 1'b0;                  // Taken by the solver
			end
		end
	end

	// Payload registers, no reset
	always_ff @(posedge clk) begin
		if (beat) begin
			for (int j = 1; j <= n_syn; j++) begin
				s_reg[j] <= s_next[j];
			end
			word_buf <= {word_buf[bch_code_pkg::code_n-2:0], in_bit}; // Position 14 first
		end
	end

	always_comb begin
		for (int j = 1; j <= n_syn; j++) begin
			syn[(j-1)*bch_gf_pkg::gf_m +: bch_gf_pkg::gf_m] = s_reg[j];
		end
	end

	assign syn_word = word_buf;

endmodule

/* sources.f */
logic/bch_gf_pkg.sv
logic/bch_code_pkg.sv
logic/bch_syndrome.sv
logic/bch_berlekamp.sv
logic/bch_chien.sv
logic/bch_decoder_top.sv
testbench/bch_decoder_checker.sv
testbench/bch_decoder_tb.sv

/* testbench/bch_decoder_checker.sv */
`timescale 1ns/100ps

module bch_decoder_checker (
	input logic               clk,
	input logic               rst_n,
	input logic               in_ready,
	input logic               out_valid,
	input logic               out_ready,
	input logic               out_bit,
	input logic               out_fail,
	input bch_code_pkg::deg_t out_nerr
);

	// **************************************************
	// Output stream handshake
	// **************************************************
	a_bit_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_bit))
		else $error("out_bit changed while the sink stalled");

	a_status_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_fail) && $stable(out_nerr))
		else $error("out_fail or out_nerr changed while the sink stalled");

	// **************************************************
	// Reset values
	// **************************************************
	a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
		else $error("in_ready low after reset");

	a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind bch_decoder_top bch_decoder_checker chk0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_bit   (out_bit),
	.out_fail  (out_fail),
	.out_nerr  (out_nerr)
);

/* testbench/bch_decoder_tb.sv */
`timescale 1ns/100ps

module bch_decoder_tb;

	localparam logic [14:0] gen_poly = 15'h0537;        // g(x) of the (15,5) code, degree 10
	localparam int nbits = bch_code_pkg::code_n;
	localparam int wait_limit = 2000;                   // Cycles allowed per wait

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_bit;
	logic in_ready;
	logic out_valid;
	logic out_bit;
	logic out_last;
	logic out_fail;
	bch_code_pkg::deg_t out_nerr;
	logic out_ready;

	integer seed;
	bit gaps;                                           // Random in_valid and out_ready gaps
	bit ready_pat [256];                                // out_ready pattern for gap runs
	int gap_q [$];                                      // Idle cycles before each input beat
	bch_code_pkg::code_word_t rx_q [$];                 // Received words, in send order
	bch_code_pkg::code_word_t exp_word_q [$];
	logic exp_fail_q [$];
	bch_code_pkg::deg_t exp_nerr_q [$];

	bch_decoder_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_bit    (in_bit),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_bit   (out_bit),
		.out_last  (out_last),
		.out_fail  (out_fail),
		.out_nerr  (out_nerr),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                          // 8 ns period
	end

	// **************************************************
	// Error handling
	// **************************************************
	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: waited %0d cycles for %s", $time, wait_limit, what);
		stop_with_failure();
	endtask

	// **************************************************
	// Reference model
	// **************************************************
	// Message polynomial times g(x)
	function automatic bch_code_pkg::code_word_t encode(input logic [4:0] msg);
		bch_code_pkg::code_word_t c;
		c = '0;
		for (int i = 0; i < 5; i++) begin
			if (msg[i]) begin
				c = c ^ (gen_poly << i);                // Shifted copy of g(x)
			end
		end
		return c;
	endfunction

	// Nearest codeword by brute force, bounded distance 3
	task automatic predict(input bch_code_pkg::code_word_t r,
			output bch_code_pkg::code_word_t w, output logic fail,
			output bch_code_pkg::deg_t nerr);
		bch_code_pkg::code_word_t c;
		int d;
		w = r;                                          // Uncorrectable words pass unchanged
		fail = 1'b1;
		nerr = '0;
		for (int m = 0; m < 32; m++) begin
			c = encode(5'(m));
			d = $countones(c ^ r);
			if (d <= bch_code_pkg::code_t) begin
				w = c;                                  // At most one codeword this close
				fail = 1'b0;
				nerr = 3'(d);
			end
		end
	endtask

	task automatic make_words(input int count, input int min_err, input int max_err);
		bch_code_pkg::code_word_t cw;
		bch_code_pkg::code_word_t flips;
		bch_code_pkg::code_word_t w;
		logic f;
		bch_code_pkg::deg_t n;
		int nflip;
		int p;
		for (int k = 0; k < count; k++) begin
			cw = encode(5'($random(seed)));
			nflip = min_err + int'($unsigned($random(seed)) % (max_err - min_err + 1));
			flips = '0;
			while ($countones(flips) < nflip) begin
				p = int'($unsigned($random(seed)) % nbits);
				flips[p] = 1'b1;                        // Distinct positions
			end
			rx_q.push_back(cw ^ flips);
			if (nflip <= bch_code_pkg::code_t) begin
				exp_word_q.push_back(cw);               // Sent codeword comes back
				exp_fail_q.push_back(1'b0);
				exp_nerr_q.push_back(3'(nflip));
			end else begin
				predict(cw ^ flips, w, f, n);
				exp_word_q.push_back(w);
				exp_fail_q.push_back(f);
				exp_nerr_q.push_back(n);
			end
			for (int i = 0; i < nbits; i++) begin
				gap_q.push_back(gaps ? int'($unsigned($random(seed)) % 3) : 0);
			end
		end
	endtask

	// **************************************************
	// Stream drivers
	// **************************************************
	task automatic send_words();
		bch_code_pkg::code_word_t w;
		int waited;
		while (rx_q.size() > 0) begin
			w = rx_q.pop_front();
			for (int i = nbits - 1; i >= 0; i--) begin
				repeat (gap_q.pop_front()) begin
					in_valid <= 1'b0;                   // Idle beat
					@(posedge clk);
				end
				in_valid <= 1'b1;
				in_bit <= w[i];                         // Position 14 first
				waited = 0;
				@(negedge clk);
				while (!in_ready) begin
					waited++;
					if (waited > wait_limit) begin
						report_timeout("in_ready");
					end
					@(negedge clk);
				end
				@(posedge clk);                         // Beat taken on this edge
			end
		end
		in_valid <= 1'b0;
	endtask

	task automatic collect_words();
		bch_code_pkg::code_word_t w;
		logic f;
		bch_code_pkg::deg_t n;
		int waited;
		int cyc;
		cyc = 0;
		while (exp_word_q.size() > 0) begin
			w = exp_word_q.pop_front();
			f = exp_fail_q.pop_front();
			n = exp_nerr_q.pop_front();
			for (int i = nbits - 1; i >= 0; i--) begin
				waited = 0;
				out_ready <= ~gaps | ready_pat[cyc % 256];
				cyc++;
				@(negedge clk);
				while (!(out_valid && out_ready)) begin
					waited++;
					if (waited > wait_limit) begin
						report_timeout("an output beat");
					end
					@(posedge clk);
					out_ready <= ~gaps | ready_pat[cyc % 256];
					cyc++;
					@(negedge clk);
				end
				check_value("out_bit", 32'(out_bit), 32'(w[i]));
				check_value("out_last", 32'(out_last), (i == 0) ? 32'd1 : 32'd0);
				check_value("out_fail", 32'(out_fail), 32'(f));
				if (!f) begin
					check_value("out_nerr", 32'(out_nerr), 32'(n));
				end
				@(posedge clk);                         // Beat taken on this edge
			end
		end
		out_ready <= 1'b1;
	endtask

	task automatic run_batch(input string label, input int count, input int min_err,
			input int max_err, input bit with_gaps);
		gaps = with_gaps;
		for (int k = 0; k < 256; k++) begin
			ready_pat[k] = ($unsigned($random(seed)) % 4) != 0;   // Ready three beats in four
		end
		make_words(count, min_err, max_err);
		fork
			send_words();
			collect_words();
		join
		repeat (40) begin
			@(negedge clk);
			check_value("out_valid after last word", 32'(out_valid), 32'd0);  // No extra beats
		end
		@(posedge clk);
		$display("%s: %0d words checked", label, count);
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial begin
		seed = 32'h0a4267ba;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_bit = 1'b0;
		out_ready = 1'b1;
		gaps = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		run_batch("No errors", 8, 0, 0, 1'b0);
		run_batch("One to three errors", 40, 1, 3, 1'b0);
		run_batch("Four to six errors", 30, 4, 6, 1'b0);
		run_batch("Random gaps", 40, 0, 6, 1'b1);
		$display(">>> PASS");
		$finish;
	end

endmodule
